//--- all.f
+incdir+include
source/calc_op_pkg.sv
source/calc_ctrl_pkg.sv
source/operand_entry.sv
source/addition.sv
source/multiply.sv
source/gencon.sv
source/calc_top.sv
tb/calc_tb.sv

//--- source/addition.sv
`timescale 1ns/1ps

module addition #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [DATA_WIDTH-1:0] in1,      // Left operand
    input  logic [DATA_WIDTH-1:0] in2,      // Right operand
    input  logic                  sub,      // 1 selects in1 - in2
    input  logic                  start,    // Single-cycle request
    output logic [DATA_WIDTH-1:0] out,      // Registered sum or difference
    output logic                  finish    // Result valid this cycle
);

    logic [DATA_WIDTH-1:0] sum;             // Combinational result
    logic [DATA_WIDTH-1:0] diff;

    always_comb begin
        sum  = in1 + in2;                   // Wraps mod 2^DATA_WIDTH
        diff = in1 - in2;                   // Unsigned borrow wraps too
    end

    // Result register, loaded only on a request
    always_ff @(posedge clk) begin
        if (start) begin
            out <= sub ? diff : sum;
        end
    end

    // One-cycle latency strobe
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Controller must never issue back-to-back starts to this unit
    a_finish_pulse: assert property (
        @(posedge clk) disable iff (!nRST)
        finish |=> !finish
    );

endmodule

//--- source/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // Controller states, binary coded
    typedef enum logic [2:0] {
        get_first_num  = 3'd0,  // Collecting first operand
        get_second_num = 3'd1,  // Collecting second operand
        send_to_unit   = 3'd2,  // Load operands, fire start
        wait_unit      = 3'd3,  // Wait on selected unit's finish
        show_result    = 3'd4   // Result on display, complete high
    } state_t;

    // Which arithmetic unit serves the latched operator
    typedef enum logic {
        unit_alu  = 1'b0,       // Adder/subtractor
        unit_mult = 1'b1        // Shift-and-add multiplier
    } unit_sel_t;

endpackage

//--- source/calc_op_pkg.sv
package calc_op_pkg;

    // One-hot operator codes as presented on operator_input
    localparam logic [2:0] op_add = 3'b001;   // Addition
    localparam logic [2:0] op_sub = 3'b010;   // Subtraction
    localparam logic [2:0] op_mul = 3'b100;   // Multiplication

    // Decoded key codes, one per cycle from the keypad front end
    // Codes 1 to 9 stand for their own digit
    localparam logic [3:0] key_none = 4'd0;   // No key this cycle
    localparam logic [3:0] key_zero = 4'd10;  // Digit zero

    // Operand and result width used when the top level is not overridden
    localparam int default_width = 16;

endpackage

//--- source/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
    parameter int DATA_WIDTH = calc_op_pkg::default_width
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            keypad_input,    // 0 none, 1-9 digits, 10 zero
    input  logic [2:0]            operator_input,  // 001 add, 010 sub, 100 mul
    input  logic                  equal_input,
    output logic                  complete,
    output logic [DATA_WIDTH-1:0] display_output
);

    logic                  entry_en1;
    logic                  entry_en2;
    logic                  entry_clr;
    logic [DATA_WIDTH-1:0] operand1;
    logic [DATA_WIDTH-1:0] operand2;
    logic [DATA_WIDTH-1:0] alu_in1;
    logic [DATA_WIDTH-1:0] alu_in2;
    logic                  sub;
    logic                  start_alu;
    logic [DATA_WIDTH-1:0] alu_out;
    logic                  alu_finish;
    logic [DATA_WIDTH-1:0] mult_in1;
    logic [DATA_WIDTH-1:0] mult_in2;
    logic                  start_mult;
    logic [DATA_WIDTH-1:0] mult_out;
    logic                  mult_finish;

    gencon #(.DATA_WIDTH(DATA_WIDTH)) u_gencon (
        .clk, .nRST, .operator_input, .equal_input,
        .operand1, .operand2,
        .alu_out, .alu_finish, .mult_out, .mult_finish,
        .entry_en1, .entry_en2, .entry_clr,
        .alu_in1, .alu_in2, .sub, .start_alu,
        .mult_in1, .mult_in2, .start_mult,
        .complete, .display_output
    );

    // Both entry blocks see every key; the enables pick the owner
    operand_entry #(.DATA_WIDTH(DATA_WIDTH)) u_entry_first (
        .clk, .nRST, .en(entry_en1), .clr(entry_clr),
        .keypad_input, .value(operand1)
    );

    operand_entry #(.DATA_WIDTH(DATA_WIDTH)) u_entry_second (
        .clk, .nRST, .en(entry_en2), .clr(entry_clr),
        .keypad_input, .value(operand2)
    );

    addition #(.DATA_WIDTH(DATA_WIDTH)) u_addition (
        .clk, .nRST, .in1(alu_in1), .in2(alu_in2), .sub,
        .start(start_alu), .out(alu_out), .finish(alu_finish)
    );

    multiply #(.DATA_WIDTH(DATA_WIDTH)) u_multiply (
        .clk, .nRST, .in1(mult_in1), .in2(mult_in2),
        .start(start_mult), .out(mult_out), .finish(mult_finish)
    );

endmodule

//--- source/gencon.sv
`timescale 1ns/1ps

module gencon #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [2:0]            operator_input,  // One-hot, level sampled
    input  logic                  equal_input,     // One-cycle pulse
    input  logic [DATA_WIDTH-1:0] operand1,        // From first entry block
    input  logic [DATA_WIDTH-1:0] operand2,        // From second entry block
    input  logic [DATA_WIDTH-1:0] alu_out,
    input  logic                  alu_finish,
    input  logic [DATA_WIDTH-1:0] mult_out,
    input  logic                  mult_finish,
    output logic                  entry_en1,       // First operand takes keys
    output logic                  entry_en2,       // Second operand takes keys
    output logic                  entry_clr,       // Wipe both operands
    output logic [DATA_WIDTH-1:0] alu_in1,
    output logic [DATA_WIDTH-1:0] alu_in2,
    output logic                  sub,             // Subtract when set
    output logic                  start_alu,
    output logic [DATA_WIDTH-1:0] mult_in1,
    output logic [DATA_WIDTH-1:0] mult_in2,
    output logic                  start_mult,
    output logic                  complete,        // One-cycle done pulse
    output logic [DATA_WIDTH-1:0] display_output   // Held result
);

    calc_ctrl_pkg::state_t    state;
    calc_ctrl_pkg::state_t    next_state;
    calc_ctrl_pkg::unit_sel_t unit_sel;            // Latched target unit

    logic                  op_valid;               // Operator is a legal code
    logic                  unit_done;              // Selected unit finished
    logic [DATA_WIDTH-1:0] unit_result;            // Selected unit's output

    always_comb begin
        op_valid = (operator_input == calc_op_pkg::op_add) ||
                   (operator_input == calc_op_pkg::op_sub) ||
                   (operator_input == calc_op_pkg::op_mul);
        if (unit_sel == calc_ctrl_pkg::unit_mult) begin
            unit_done   = mult_finish;
            unit_result = mult_out;
        end else begin
            unit_done   = alu_finish;
            unit_result = alu_out;
        end
    end

    // Next-state logic
    always_comb begin
        next_state = state;
        case (state)
            calc_ctrl_pkg::get_first_num: begin
                if (op_valid) begin
                    next_state = calc_ctrl_pkg::get_second_num;
                end
            end
            calc_ctrl_pkg::get_second_num: begin
                if (equal_input) begin
                    next_state = calc_ctrl_pkg::send_to_unit;
                end
            end
            calc_ctrl_pkg::send_to_unit: next_state = calc_ctrl_pkg::wait_unit;
            calc_ctrl_pkg::wait_unit: begin
                if (unit_done) begin               // Ignore the other unit
                    next_state = calc_ctrl_pkg::show_result;
                end
            end
            calc_ctrl_pkg::show_result: next_state = calc_ctrl_pkg::get_first_num;
            default: next_state = calc_ctrl_pkg::get_first_num;
        endcase
    end

    assign entry_clr = (state == calc_ctrl_pkg::show_result); // New calc next

    // State and control registers
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= calc_ctrl_pkg::get_first_num;
            unit_sel       <= calc_ctrl_pkg::unit_alu;
            sub            <= 1'b0;
            start_alu      <= 1'b0;
            start_mult     <= 1'b0;
            entry_en1      <= 1'b0;
            entry_en2      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            entry_en1 <= (next_state == calc_ctrl_pkg::get_first_num);
            entry_en2 <= (next_state == calc_ctrl_pkg::get_second_num);
            // Operator latched on the edge that ends first-operand entry
            if (state == calc_ctrl_pkg::get_first_num && op_valid) begin
                unit_sel <= (operator_input == calc_op_pkg::op_mul) ?
                            calc_ctrl_pkg::unit_mult : calc_ctrl_pkg::unit_alu;
                sub      <= (operator_input == calc_op_pkg::op_sub);
            end
            // Start pulses for exactly one cycle after send_to_unit
            start_alu  <= (state == calc_ctrl_pkg::send_to_unit) &&
                          (unit_sel == calc_ctrl_pkg::unit_alu);
            start_mult <= (state == calc_ctrl_pkg::send_to_unit) &&
                          (unit_sel == calc_ctrl_pkg::unit_mult);
            complete   <= (state == calc_ctrl_pkg::wait_unit) && unit_done;
            if (state == calc_ctrl_pkg::wait_unit && unit_done) begin
                display_output <= unit_result;     // Held until next result
            end
        end
    end

    // Operand routing, stable from start until finish
    always_ff @(posedge clk) begin
        if (state == calc_ctrl_pkg::send_to_unit) begin
            if (unit_sel == calc_ctrl_pkg::unit_mult) begin
                mult_in1 <= operand1;
                mult_in2 <= operand2;
            end else begin
                alu_in1 <= operand1;
                alu_in2 <= operand2;
            end
        end
    end

    // Only one unit runs per calculation
    a_one_start: assert property (
        @(posedge clk) disable iff (!nRST)
        !(start_alu && start_mult)
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (!nRST)
        state inside {calc_ctrl_pkg::get_first_num, calc_ctrl_pkg::get_second_num,
                      calc_ctrl_pkg::send_to_unit, calc_ctrl_pkg::wait_unit,
                      calc_ctrl_pkg::show_result}
    );

    // Done pulse lines up with the result state
    a_complete_state: assert property (
        @(posedge clk) disable iff (!nRST)
        $rose(complete) |-> (state == calc_ctrl_pkg::show_result)
    );

endmodule

//--- source/multiply.sv
`timescale 1ns/1ps

module multiply #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [DATA_WIDTH-1:0] in1,      // Multiplicand
    input  logic [DATA_WIDTH-1:0] in2,      // Multiplier
    input  logic                  start,    // Single-cycle request
    output logic [DATA_WIDTH-1:0] out,      // Low half of product
    output logic                  finish    // Product valid this cycle
);

    localparam int CNT_W = $clog2(DATA_WIDTH);  // Holds DATA_WIDTH-1

    logic [DATA_WIDTH-1:0] mcand;           // Shifted multiplicand
    logic [DATA_WIDTH-1:0] mplier;          // Remaining multiplier bits
    logic [CNT_W-1:0]      count;           // Iterations still to do
    logic                  busy;            // Product in progress
    logic                  last_step;       // Final partial product now

    assign last_step = busy && (count == CNT_W'(1));

    // Datapath. First partial product is taken at the load edge so the
    // remaining DATA_WIDTH-1 bits finish exactly DATA_WIDTH cycles later
    always_ff @(posedge clk) begin
        if (start) begin
            out    <= in2[0] ? in1 : '0;
            mcand  <= in1 << 1;
            mplier <= in2 >> 1;
        end else if (busy) begin
            if (mplier[0]) begin
                out <= out + mcand;         // Add this partial product
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Sequencing
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;
            if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(DATA_WIDTH - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (last_step) begin
                    busy <= 1'b0;           // Done after this edge
                end
            end
        end
    end

    // Controller only starts this unit while it is idle
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST)
        $rose(start) |-> !busy
    );

endmodule

//--- source/operand_entry.sv
`timescale 1ns/1ps

module operand_entry #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  en,             // Accept keys this cycle
    input  logic                  clr,            // Start a fresh operand
    input  logic [3:0]            keypad_input,   // Decoded key code
    output logic [DATA_WIDTH-1:0] value           // Accumulated operand
);

    logic [3:0]            digit;       // Numeric value of the key
    logic                  key_valid;   // Any key pressed
    logic [DATA_WIDTH-1:0] times_ten;   // value * 10, wrapped

    always_comb begin
        key_valid = (keypad_input != calc_op_pkg::key_none);
        if (keypad_input == calc_op_pkg::key_zero) begin
            digit = 4'd0;                        // Code 10 is the zero key
        end else begin
            digit = keypad_input;
        end
        times_ten = (value << 3) + (value << 1); // 8x + 2x
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clr) begin
            value <= '0;                         // Clear wins over a key
        end else if (en && key_valid) begin
            value <= times_ten + DATA_WIDTH'(digit);
        end
    end

    // Front end only ever sends codes 0 to 10
    a_key_range: assert property (
        @(posedge clk) disable iff (!nRST)
        en |-> (keypad_input <= calc_op_pkg::key_zero)
    );

endmodule

//--- include/calc_tb_model.svh
`ifndef CALC_TB_MODEL_SVH
`define CALC_TB_MODEL_SVH

// Keep the low width bits of a value
function automatic int unsigned wrap_to_width(input int unsigned value, input int width);
    if (width >= 32) begin
        return value;
    end
    return value & ((32'd1 << width) - 32'd1);
endfunction

// Numeric digit of a key code where code 10 is zero
function automatic int unsigned key_to_digit(input logic [3:0] key);
    if (key == calc_op_pkg::key_zero) begin
        return 0;
    end
    return int'(key);
endfunction

// One key step of decimal entry
function automatic int unsigned accumulate_digit(input int unsigned acc,
                                                 input logic [3:0] key,
                                                 input int width);
    if (key == calc_op_pkg::key_none) begin
        return acc;                                 // No key leaves the value alone
    end
    return wrap_to_width(acc * 10 + key_to_digit(key), width);
endfunction

// Whole operand from its key list
function automatic int unsigned operand_from_keys(input logic [3:0] keys[$], input int width);
    int unsigned acc;
    acc = 0;
    foreach (keys[i]) begin
        acc = accumulate_digit(acc, keys[i], width);
    end
    return acc;
endfunction

// Operator arithmetic wrapped to width
function automatic int unsigned apply_operator(input int unsigned a, input int unsigned b,
                                               input logic [2:0] op, input int width);
    case (op)
        calc_op_pkg::op_add: return wrap_to_width(a + b, width);
        calc_op_pkg::op_sub: return wrap_to_width(a - b, width);
        calc_op_pkg::op_mul: return wrap_to_width(a * b, width);
        default:             return 0;
    endcase
endfunction

`endif

//--- tb/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;

    localparam int          DATA_WIDTH   = 16;
    localparam int          CLK_PERIOD   = 20;             // ns
    localparam logic [31:0] SEED         = 32'hfd3d9652;
    localparam int          MAX_DIGITS   = 5;              // Digits per operand
    localparam int          MAX_GAP      = 2;              // Idle cycles between keys
    localparam int          MAX_KEYS     = 2 * MAX_DIGITS * (MAX_GAP + 1) + 4;
    localparam int          NUM_ADDSUB   = 14;
    localparam int          NUM_MUL      = 10;
    localparam int          NUM_NOISY    = 8;
    localparam int          NUM_B2B      = 6;
    localparam int          NUM_SEQ      = NUM_ADDSUB + NUM_MUL + NUM_NOISY + NUM_B2B;
    localparam int          MAX_WAIT     = DATA_WIDTH + 10; // Cycles from equal to complete
    localparam int          LIMIT_CYCLES = NUM_SEQ * (MAX_KEYS + DATA_WIDTH + 10);

    logic                  clk;
    logic                  nRST;
    logic [3:0]            keypad_input;
    logic [2:0]            operator_input;
    logic                  equal_input;
    logic                  complete;
    logic [DATA_WIDTH-1:0] display_output;

    int                    check_count;
    int                    error_count;
    int                    test_count;
    int                    test_fail_count;
    int                    complete_count;   // Pulses seen by the monitor
    int                    calc_count;       // Calculations issued
    logic [DATA_WIDTH-1:0] held_display;     // Model result the display must hold
    bit                    monitor_on;

    `include "calc_tb_model.svh"

    calc_top #(.DATA_WIDTH(DATA_WIDTH)) uut (
        .clk, .nRST, .keypad_input, .operator_input, .equal_input,
        .complete, .display_output
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Compare and report
    task automatic check_value(input int unsigned actual, input int unsigned expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    // Drive one input cycle just after the rising edge
    task automatic apply_inputs(input logic [3:0] key, input logic [2:0] op, input logic eq);
        @(posedge clk);
        #1;
        keypad_input   = key;
        operator_input = op;
        equal_input    = eq;
    endtask

    function automatic logic [3:0] random_digit_key();
        return 4'($urandom_range(1, 10));       // 10 is the zero key
    endfunction

    function automatic logic [2:0] random_operator();
        case ($urandom_range(0, 2))
            0:       return calc_op_pkg::op_add;
            1:       return calc_op_pkg::op_sub;
            default: return calc_op_pkg::op_mul;
        endcase
    endfunction

    // Any code other than the three one-hot operators
    function automatic logic [2:0] invalid_operator();
        logic [2:0] code;
        code = 3'($urandom_range(0, 7));
        while (code == calc_op_pkg::op_add || code == calc_op_pkg::op_sub ||
               code == calc_op_pkg::op_mul) begin
            code = 3'($urandom_range(0, 7));
        end
        return code;
    endfunction

    function automatic string op_symbol(input logic [2:0] op);
        case (op)
            calc_op_pkg::op_add: return "+";
            calc_op_pkg::op_sub: return "-";
            default:             return "*";
        endcase
    endfunction

    // Keys of one operand with random idle gaps
    task automatic enter_keys(input logic [3:0] keys[$], input int max_gap, input bit bad_ops);
        int gap;
        foreach (keys[i]) begin
            gap = $urandom_range(0, max_gap);
            repeat (gap) begin
                apply_inputs(calc_op_pkg::key_none, bad_ops ? invalid_operator() : 3'b000, 1'b0);
            end
            apply_inputs(keys[i], bad_ops ? invalid_operator() : 3'b000, 1'b0);
        end
    endtask

    // Sample at falling edge; optional junk keys and equal pulses while busy
    task automatic wait_for_complete(input bit noisy, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < MAX_WAIT) begin
            @(negedge clk);
            if (complete) begin
                seen = 1'b1;
            end else begin
                cycles++;
                if (noisy) begin
                    apply_inputs(4'($urandom_range(0, 10)), 3'b000, 1'($urandom_range(0, 1)));
                end else begin
                    apply_inputs(calc_op_pkg::key_none, 3'b000, 1'b0);
                end
            end
        end
        apply_inputs(calc_op_pkg::key_none, 3'b000, 1'b0);  // Quiet before next calc
    endtask

    // Full calculation from operand keys to checked result
    task automatic run_calc(input logic [2:0] op, input int max_gap, input bit noisy,
                            input bit bad_ops, input string label);
        logic [3:0]  keys1[$];
        logic [3:0]  keys2[$];
        int          n1;
        int          n2;
        int          errors_before;
        int          pulses_before;
        int unsigned a;
        int unsigned b;
        int unsigned expected;
        bit          seen;
        n1 = $urandom_range(1, MAX_DIGITS);
        n2 = $urandom_range(1, MAX_DIGITS);
        repeat (n1) keys1.push_back(random_digit_key());
        repeat (n2) keys2.push_back(random_digit_key());
        a        = operand_from_keys(keys1, DATA_WIDTH);
        b        = operand_from_keys(keys2, DATA_WIDTH);
        expected = apply_operator(a, b, op, DATA_WIDTH);
        errors_before = error_count;
        pulses_before = complete_count;
        enter_keys(keys1, max_gap, bad_ops);
        apply_inputs(calc_op_pkg::key_none, op, 1'b0);     // Operator for one cycle
        enter_keys(keys2, max_gap, 1'b0);
        apply_inputs(calc_op_pkg::key_none, 3'b000, 1'b1); // Equal pulse
        wait_for_complete(noisy, seen);
        calc_count++;
        if (!seen) begin
            error_count++;
            $display("Timeout at %0t ns: %s never pulsed complete within %0d cycles of equal",
                     $time, label, MAX_WAIT);
        end else begin
            check_value(display_output, expected, {label, " result"});
            check_value(complete_count - pulses_before, 1, {label, " complete pulse count"});
            held_display = DATA_WIDTH'(expected);          // Display holds this from now on
        end
        test_count++;
        if (error_count != errors_before) begin
            test_fail_count++;
        end
        $display("Test %0d %s: %0d %s %0d = %0d (model %0d) %s", test_count, label, a,
                 op_symbol(op), b, display_output, expected,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    // Counts complete pulses and checks display holds between them
    always @(negedge clk) begin
        if (monitor_on) begin
            if (complete) begin
                complete_count++;
            end else if (display_output !== held_display) begin
                check_value(display_output, held_display, "display changed without complete");
            end
        end
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * LIMIT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int errors_before;
        void'($urandom(SEED));
        keypad_input    = calc_op_pkg::key_none;
        operator_input  = 3'b000;
        equal_input     = 1'b0;
        nRST            = 1'b0;
        check_count     = 0;
        error_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        complete_count  = 0;
        calc_count      = 0;
        held_display    = '0;
        monitor_on      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        nRST       = 1'b1;
        monitor_on = 1'b1;

        errors_before = error_count;
        check_value(complete, 0, "complete after reset");
        check_value(display_output, 0, "display after reset");
        test_count++;
        if (error_count != errors_before) begin
            test_fail_count++;
        end
        $display("Test %0d reset: complete %0b display %0d %s", test_count, complete,
                 display_output, (error_count == errors_before) ? "ok" : "mismatch");

        repeat (NUM_ADDSUB) begin
            run_calc($urandom_range(0, 1) ? calc_op_pkg::op_sub : calc_op_pkg::op_add,
                     MAX_GAP, 1'b0, 1'b0, "add/sub");
        end
        repeat (NUM_MUL) run_calc(calc_op_pkg::op_mul, MAX_GAP, 1'b0, 1'b0, "multiply");
        repeat (NUM_NOISY) run_calc(random_operator(), MAX_GAP, 1'b1, 1'b1, "busy noise");
        repeat (NUM_B2B) run_calc(random_operator(), 0, 1'b0, 1'b0, "back-to-back");

        // No stray pulses after the last result
        repeat (5) apply_inputs(calc_op_pkg::key_none, 3'b000, 1'b0);
        check_value(complete_count, calc_count, "total complete pulses");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
